//--- common/mips_macros.svh
`ifndef MIPS_MACROS_SVH
`define MIPS_MACROS_SVH

`define MIPS_OPC_SPECIAL 6'b000000
`define MIPS_OPC_ADDIU   6'b001001
`define MIPS_OPC_LUI     6'b001111
`define MIPS_OPC_LW      6'b100011
`define MIPS_OPC_SW      6'b101011
`define MIPS_OPC_BEQ     6'b000100
`define MIPS_OPC_BNE     6'b000101

`define MIPS_FN_ADDU     6'b100001
`define MIPS_FN_SUBU     6'b100011
`define MIPS_FN_AND      6'b100100
`define MIPS_FN_OR       6'b100101
`define MIPS_FN_SLT      6'b101010

`define MIPS_RESET_PC    32'h0000_0000
`define MIPS_NOP         32'h0000_0000

`endif

//--- common/mips_pkg.sv
`default_nettype none

package mips_pkg;

    typedef logic [31:0] word_t;      // Data word, address or instruction
    typedef logic [4:0]  reg_addr_t;
    typedef logic [2:0]  alu_op_t;

    localparam alu_op_t ALU_ADD = 3'd0;
    localparam alu_op_t ALU_SUB = 3'd1;
    localparam alu_op_t ALU_AND = 3'd2;
    localparam alu_op_t ALU_OR  = 3'd3;
    localparam alu_op_t ALU_SLT = 3'd4;
    localparam alu_op_t ALU_LUI = 3'd5;  // Immediate into the upper half

endpackage

`default_nettype wire

//--- hw/regfile.sv
`default_nettype none

module regfile (
    input  wire         clk,
    input  wire         rst_n,
    input  wire         we_i,
    input  wire  [4:0]  waddr_i,
    input  wire  [4:0]  raddr1_i,
    input  wire  [4:0]  raddr2_i,
    input  wire  [31:0] wdata_i,
    output logic [31:0] rdata1_o,
    output logic [31:0] rdata2_o
);

    logic [31:0] regs [32];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < 32; i++)
                regs[i] <= '0;
        end else if (we_i && waddr_i != 5'd0) begin
            regs[waddr_i] <= wdata_i;           // r0 stays zero
        end
    end

    assign rdata1_o = (raddr1_i == 5'd0) ? 32'd0 : regs[raddr1_i];
    assign rdata2_o = (raddr2_i == 5'd0) ? 32'd0 : regs[raddr2_i];

endmodule

`default_nettype wire

//--- hw/bus_arbiter.sv
`default_nettype none

module bus_arbiter (
    input  wire                  mem_read_i,
    input  wire                  mem_write_i,
    input  wire mips_pkg::word_t mem_addr_i,
    input  wire mips_pkg::word_t mem_wrdata_i,
    input  wire mips_pkg::word_t pc_i,
    output logic                 fetch_grant_o,
    output logic                 bus_read_o,
    output logic                 bus_write_o,
    output mips_pkg::word_t      bus_address_o,
    output mips_pkg::word_t      bus_wrdata_o
);

    logic mem_req;

    assign mem_req       = mem_read_i || mem_write_i;
    assign fetch_grant_o = !mem_req;                        // Data stage has priority
    assign bus_read_o    = mem_read_i || !mem_req;          // Fetch reads when bus is free
    assign bus_write_o   = mem_write_i;
    assign bus_address_o = mem_req ? mem_addr_i : pc_i;
    assign bus_wrdata_o  = mem_write_i ? mem_wrdata_i : '0;

endmodule

`default_nettype wire

//--- core/fetch_unit.sv
`default_nettype none
`include "mips_macros.svh"

module fetch_unit (
    input  wire                  clk,
    input  wire                  rst_n,
    input  wire                  fetch_grant_i,
    input  wire                  load_stall_i,
    input  wire                  branch_taken_i,
    input  wire mips_pkg::word_t branch_target_i,
    input  wire mips_pkg::word_t inst_i,
    output mips_pkg::word_t      pc_o,
    output mips_pkg::word_t      if_inst_o,
    output mips_pkg::word_t      if_pc_o
);
    import mips_pkg::*;

    logic  redirect_pending;        // Taken branch seen while the bus was busy
    word_t redirect_target;
    word_t pc_next;

    always_comb begin
        if (redirect_pending)
            pc_next = redirect_target;
        else if (branch_taken_i)
            pc_next = branch_target_i;
        else
            pc_next = pc_o + 32'd4;
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pc_o             <= `MIPS_RESET_PC;
            if_inst_o        <= `MIPS_NOP;
            redirect_pending <= 1'b0;
        end else if (!load_stall_i) begin
            if (fetch_grant_i) begin
                pc_o             <= pc_next;
                if_inst_o        <= inst_i;
                redirect_pending <= 1'b0;
            end else begin
                if_inst_o <= `MIPS_NOP;     // Same PC is fetched again
                if (branch_taken_i)
                    redirect_pending <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!load_stall_i && fetch_grant_i)
            if_pc_o <= pc_o;
        if (branch_taken_i)
            redirect_target <= branch_target_i;
    end

endmodule

`default_nettype wire

//--- core/decode_unit.sv
`default_nettype none
`include "mips_macros.svh"

module decode_unit (
    input  wire                      clk,
    input  wire                      rst_n,
    input  wire mips_pkg::word_t     if_inst_i,
    input  wire mips_pkg::word_t     if_pc_i,
    input  wire mips_pkg::word_t     rs_data_i,
    input  wire mips_pkg::word_t     rt_data_i,
    input  wire mips_pkg::reg_addr_t ex_dest_i,
    input  wire mips_pkg::word_t     ex_result_i,
    input  wire                      ex_is_load_i,
    input  wire mips_pkg::reg_addr_t mm_dest_i,
    input  wire mips_pkg::word_t     mm_result_i,
    input  wire                      wb_we_i,
    input  wire mips_pkg::reg_addr_t wb_addr_i,
    input  wire mips_pkg::word_t     wb_data_i,
    output mips_pkg::reg_addr_t      rs_addr_o,
    output mips_pkg::reg_addr_t      rt_addr_o,
    output logic                     load_stall_o,
    output logic                     branch_taken_o,
    output mips_pkg::word_t          branch_target_o,
    output mips_pkg::alu_op_t        id_alu_op_o,
    output mips_pkg::word_t          id_op_a_o,
    output mips_pkg::word_t          id_op_b_o,
    output mips_pkg::word_t          id_store_data_o,
    output mips_pkg::reg_addr_t      id_dest_o,
    output logic                     id_is_load_o,
    output logic                     id_is_store_o
);
    import mips_pkg::*;

    logic [5:0] opcode;
    logic [5:0] funct;
    word_t      imm_sext;
    reg_addr_t  dest;
    alu_op_t    alu_op;
    logic       use_imm, uses_rs, uses_rt;
    logic       is_load, is_store, is_beq, is_bne;
    word_t      src_a, src_b;

    assign opcode    = if_inst_i[31:26];
    assign funct     = if_inst_i[5:0];
    assign imm_sext  = {{16{if_inst_i[15]}}, if_inst_i[15:0]};
    assign rs_addr_o = if_inst_i[25:21];
    assign rt_addr_o = if_inst_i[20:16];

    always_comb begin
        alu_op   = ALU_ADD;
        use_imm  = 1'b1;
        uses_rs  = 1'b1;
        uses_rt  = 1'b0;
        dest     = '0;
        is_load  = 1'b0;
        is_store = 1'b0;
        is_beq   = 1'b0;
        is_bne   = 1'b0;
        case (opcode)
            `MIPS_OPC_SPECIAL: begin
                use_imm = 1'b0;
                uses_rt = 1'b1;
                dest    = if_inst_i[15:11];
                case (funct)
                    `MIPS_FN_ADDU: alu_op = ALU_ADD;
                    `MIPS_FN_SUBU: alu_op = ALU_SUB;
                    `MIPS_FN_AND:  alu_op = ALU_AND;
                    `MIPS_FN_OR:   alu_op = ALU_OR;
                    `MIPS_FN_SLT:  alu_op = ALU_SLT;
                    default: begin
                        dest    = '0;        // Unsupported funct runs as a no-op
                        uses_rs = 1'b0;
                        uses_rt = 1'b0;
                    end
                endcase
            end
            `MIPS_OPC_ADDIU: dest = rt_addr_o;
            `MIPS_OPC_LUI: begin
                alu_op  = ALU_LUI;
                uses_rs = 1'b0;
                dest    = rt_addr_o;
            end
            `MIPS_OPC_LW: begin
                is_load = 1'b1;
                dest    = rt_addr_o;
            end
            `MIPS_OPC_SW: begin
                is_store = 1'b1;
                uses_rt  = 1'b1;
            end
            `MIPS_OPC_BEQ: begin
                is_beq  = 1'b1;
                uses_rt = 1'b1;
            end
            `MIPS_OPC_BNE: begin
                is_bne  = 1'b1;
                uses_rt = 1'b1;
            end
            default: uses_rs = 1'b0;
        endcase
    end

    // Youngest producer wins, r0 is never forwarded
    function automatic word_t forward(input reg_addr_t src, input word_t rf_val);
        if (src != '0 && src == ex_dest_i && !ex_is_load_i)
            return ex_result_i;
        if (src != '0 && src == mm_dest_i)
            return mm_result_i;
        if (src != '0 && wb_we_i && src == wb_addr_i)
            return wb_data_i;
        return rf_val;
    endfunction

    always_comb begin
        src_a = forward(rs_addr_o, rs_data_i);
        src_b = forward(rt_addr_o, rt_data_i);
    end

    assign load_stall_o = ex_is_load_i && ex_dest_i != '0 &&
                          ((uses_rs && ex_dest_i == rs_addr_o) ||
                           (uses_rt && ex_dest_i == rt_addr_o));

    assign branch_target_o = if_pc_i + 32'd4 + {imm_sext[29:0], 2'b00};
    assign branch_taken_o  = !load_stall_o &&
                             ((is_beq && src_a == src_b) || (is_bne && src_a != src_b));

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            id_dest_o     <= '0;
            id_is_load_o  <= 1'b0;
            id_is_store_o <= 1'b0;
        end else begin
            id_dest_o     <= load_stall_o ? '0 : dest;      // Bubble while held
            id_is_load_o  <= !load_stall_o && is_load;
            id_is_store_o <= !load_stall_o && is_store;
        end
    end

    always_ff @(posedge clk) begin
        id_alu_op_o     <= alu_op;
        id_op_a_o       <= src_a;
        id_op_b_o       <= use_imm ? imm_sext : src_b;
        id_store_data_o <= src_b;
    end

endmodule

`default_nettype wire

//--- core/exec_unit.sv
`default_nettype none

module exec_unit (
    input  wire                      clk,
    input  wire                      rst_n,
    input  wire mips_pkg::alu_op_t   id_alu_op_i,
    input  wire mips_pkg::word_t     id_op_a_i,
    input  wire mips_pkg::word_t     id_op_b_i,
    input  wire mips_pkg::word_t     id_store_data_i,
    input  wire mips_pkg::reg_addr_t id_dest_i,
    input  wire                      id_is_load_i,
    input  wire                      id_is_store_i,
    output mips_pkg::word_t          ex_result_o,
    output mips_pkg::reg_addr_t      ex_dest_o,
    output logic                     ex_is_load_o,
    output mips_pkg::word_t          mm_addr_o,
    output mips_pkg::word_t          mm_store_data_o,
    output mips_pkg::reg_addr_t      mm_dest_o,
    output logic                     mm_is_load_o,
    output logic                     mm_is_store_o
);
    import mips_pkg::*;

    always_comb begin
        case (id_alu_op_i)
            ALU_SUB: ex_result_o = id_op_a_i - id_op_b_i;
            ALU_AND: ex_result_o = id_op_a_i & id_op_b_i;
            ALU_OR:  ex_result_o = id_op_a_i | id_op_b_i;
            ALU_SLT: ex_result_o = {31'd0, $signed(id_op_a_i) < $signed(id_op_b_i)};
            ALU_LUI: ex_result_o = {id_op_b_i[15:0], 16'h0000};
            default: ex_result_o = id_op_a_i + id_op_b_i;   // Also the load/store address
        endcase
    end

    assign ex_dest_o    = id_dest_i;
    assign ex_is_load_o = id_is_load_i;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            mm_dest_o     <= '0;
            mm_is_load_o  <= 1'b0;
            mm_is_store_o <= 1'b0;
        end else begin
            mm_dest_o     <= id_dest_i;
            mm_is_load_o  <= id_is_load_i;
            mm_is_store_o <= id_is_store_i;
        end
    end

    always_ff @(posedge clk) begin
        mm_addr_o       <= ex_result_o;
        mm_store_data_o <= id_store_data_i;
    end

endmodule

`default_nettype wire

//--- core/mem_unit.sv
`default_nettype none

module mem_unit (
    input  wire                      clk,
    input  wire                      rst_n,
    input  wire mips_pkg::word_t     mm_addr_i,
    input  wire mips_pkg::word_t     mm_store_data_i,
    input  wire mips_pkg::reg_addr_t mm_dest_i,
    input  wire                      mm_is_load_i,
    input  wire                      mm_is_store_i,
    input  wire mips_pkg::word_t     bus_rddata_i,
    output logic                     mem_read_o,
    output logic                     mem_write_o,
    output mips_pkg::word_t          mem_addr_o,
    output mips_pkg::word_t          mem_wrdata_o,
    output mips_pkg::word_t          mm_result_o,
    output logic                     wb_we_o,
    output mips_pkg::reg_addr_t      wb_addr_o,
    output mips_pkg::word_t          wb_data_o
);

    assign mem_read_o   = mm_is_load_i;
    assign mem_write_o  = mm_is_store_i;
    assign mem_addr_o   = mm_addr_i;
    assign mem_wrdata_o = mm_store_data_i;
    assign mm_result_o  = mm_is_load_i ? bus_rddata_i : mm_addr_i;  // Load data arrives this cycle

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wb_we_o   <= 1'b0;
            wb_addr_o <= '0;
        end else begin
            wb_we_o   <= mm_dest_i != '0;
            wb_addr_o <= mm_dest_i;
        end
    end

    always_ff @(posedge clk) begin
        wb_data_o <= mm_result_o;
    end

endmodule

`default_nettype wire

//--- hw/mips_core_top.sv
`default_nettype none

module mips_core_top (
    input  wire                  clk,
    input  wire                  rst_n,
    input  wire mips_pkg::word_t bus_rddata_i,
    output wire mips_pkg::word_t bus_address_o,
    output wire mips_pkg::word_t bus_wrdata_o,
    output wire                  bus_read_o,
    output wire                  bus_write_o
);
    import mips_pkg::*;

    wire word_t     pc, if_inst, if_pc, branch_target;
    wire            fetch_grant, load_stall, branch_taken;
    wire reg_addr_t rs_addr, rt_addr;
    wire word_t     rs_data, rt_data;
    wire alu_op_t   id_alu_op;
    wire word_t     id_op_a, id_op_b, id_store_data;
    wire reg_addr_t id_dest;
    wire            id_is_load, id_is_store;
    wire word_t     ex_result;
    wire reg_addr_t ex_dest;
    wire            ex_is_load;
    wire word_t     mm_addr, mm_store_data, mm_result;
    wire reg_addr_t mm_dest;
    wire            mm_is_load, mm_is_store;
    wire            mem_read, mem_write;
    wire word_t     mem_addr, mem_wrdata;
    wire            wb_we;
    wire reg_addr_t wb_addr;
    wire word_t     wb_data;

    fetch_unit u_fetch (
        .clk(clk), .rst_n(rst_n),
        .fetch_grant_i(fetch_grant), .load_stall_i(load_stall),
        .branch_taken_i(branch_taken), .branch_target_i(branch_target),
        .inst_i(bus_rddata_i),
        .pc_o(pc), .if_inst_o(if_inst), .if_pc_o(if_pc)
    );

    decode_unit u_decode (
        .clk(clk), .rst_n(rst_n),
        .if_inst_i(if_inst), .if_pc_i(if_pc),
        .rs_data_i(rs_data), .rt_data_i(rt_data),
        .ex_dest_i(ex_dest), .ex_result_i(ex_result), .ex_is_load_i(ex_is_load),
        .mm_dest_i(mm_dest), .mm_result_i(mm_result),
        .wb_we_i(wb_we), .wb_addr_i(wb_addr), .wb_data_i(wb_data),
        .rs_addr_o(rs_addr), .rt_addr_o(rt_addr),
        .load_stall_o(load_stall), .branch_taken_o(branch_taken),
        .branch_target_o(branch_target),
        .id_alu_op_o(id_alu_op), .id_op_a_o(id_op_a), .id_op_b_o(id_op_b),
        .id_store_data_o(id_store_data), .id_dest_o(id_dest),
        .id_is_load_o(id_is_load), .id_is_store_o(id_is_store)
    );

    exec_unit u_exec (
        .clk(clk), .rst_n(rst_n),
        .id_alu_op_i(id_alu_op), .id_op_a_i(id_op_a), .id_op_b_i(id_op_b),
        .id_store_data_i(id_store_data), .id_dest_i(id_dest),
        .id_is_load_i(id_is_load), .id_is_store_i(id_is_store),
        .ex_result_o(ex_result), .ex_dest_o(ex_dest), .ex_is_load_o(ex_is_load),
        .mm_addr_o(mm_addr), .mm_store_data_o(mm_store_data), .mm_dest_o(mm_dest),
        .mm_is_load_o(mm_is_load), .mm_is_store_o(mm_is_store)
    );

    mem_unit u_mem (
        .clk(clk), .rst_n(rst_n),
        .mm_addr_i(mm_addr), .mm_store_data_i(mm_store_data), .mm_dest_i(mm_dest),
        .mm_is_load_i(mm_is_load), .mm_is_store_i(mm_is_store),
        .bus_rddata_i(bus_rddata_i),
        .mem_read_o(mem_read), .mem_write_o(mem_write),
        .mem_addr_o(mem_addr), .mem_wrdata_o(mem_wrdata), .mm_result_o(mm_result),
        .wb_we_o(wb_we), .wb_addr_o(wb_addr), .wb_data_o(wb_data)
    );

    regfile u_regfile (
        .clk(clk), .rst_n(rst_n),
        .we_i(wb_we), .waddr_i(wb_addr), .wdata_i(wb_data),
        .raddr1_i(rs_addr), .raddr2_i(rt_addr),
        .rdata1_o(rs_data), .rdata2_o(rt_data)
    );

    bus_arbiter u_arbiter (
        .mem_read_i(mem_read), .mem_write_i(mem_write),
        .mem_addr_i(mem_addr), .mem_wrdata_i(mem_wrdata), .pc_i(pc),
        .fetch_grant_o(fetch_grant),
        .bus_read_o(bus_read_o), .bus_write_o(bus_write_o),
        .bus_address_o(bus_address_o), .bus_wrdata_o(bus_wrdata_o)
    );

endmodule

`default_nettype wire

//--- testbench/mips_chk.sv
`default_nettype none

module mips_chk (
    input wire                  clk,
    input wire                  rst_n,
    input wire                  bus_read_i,
    input wire                  bus_write_i,
    input wire mips_pkg::word_t bus_address_i
);

    int fail_count;

    initial fail_count = 0;

    strobe_exclusive: assert property (@(posedge clk) disable iff (!rst_n)
        !(bus_read_i && bus_write_i))
        else begin
            $error("bus read and write strobes are high together");
            fail_count++;
        end

    // Byte and halfword accesses are not supported
    address_aligned: assert property (@(posedge clk) disable iff (!rst_n)
        (bus_read_i || bus_write_i) |-> bus_address_i[1:0] == 2'b00)
        else begin
            $error("strobed bus address is not word aligned");
            fail_count++;
        end

    write_quiet_after_reset: assert property (@(posedge clk)
        $rose(rst_n) |-> !bus_write_i)
        else begin
            $error("bus write strobe high in the first cycle after reset");
            fail_count++;
        end

endmodule

bind mips_core_top mips_chk u_chk (
    .clk(clk),
    .rst_n(rst_n),
    .bus_read_i(bus_read_o),
    .bus_write_i(bus_write_o),
    .bus_address_i(bus_address_o)
);

`default_nettype wire

//--- testbench/tb_mips.sv
`default_nettype none
`include "mips_macros.svh"

module tb_mips;
    import mips_pkg::*;

    localparam int    MEM_WORDS    = 256;
    localparam int    FILE_WORDS   = 128;
    localparam int    MAX_RECORDS  = 32;
    localparam int    DONE_LIMIT   = 2000;
    localparam int    QUIET_CYCLES = 100;
    localparam word_t MARKER       = 32'hffff_ffff;    // Closes each file section
    localparam int    PROG_BASE    = `MIPS_RESET_PC >> 2;

    logic  clk;
    logic  rst_n;
    word_t bus_rddata;
    word_t bus_address;
    word_t bus_wrdata;
    logic  bus_read;
    logic  bus_write;

    word_t mem [MEM_WORDS];
    word_t file_buf [FILE_WORDS];
    word_t rec_addr [MAX_RECORDS];
    word_t rec_data [MAX_RECORDS];
    int    rec_test [MAX_RECORDS];
    int    n_rec;
    int    rec_idx;
    int    checks;
    int    errors;
    int    test_errs [1:5];
    bit    test_done [1:5];

    mips_core_top dut (
        .clk(clk), .rst_n(rst_n), .bus_rddata_i(bus_rddata),
        .bus_address_o(bus_address), .bus_wrdata_o(bus_wrdata),
        .bus_read_o(bus_read), .bus_write_o(bus_write)
    );

    assign bus_rddata = mem[bus_address[9:2]];     // Same-cycle read that wraps at 1 KB

    always #4 clk = ~clk;

    function automatic string test_name(input int test);
        case (test)
            1: return "reset quiet";
            2: return "forwarded ALU chain";
            3: return "load-use";
            4: return "branches with delay slot";
            5: return "completion and order";
            default: return "unknown";
        endcase
    endfunction

    task automatic report_test(input int test);
        test_done[test] = 1'b1;
        if (test_errs[test] == 0)
            $display("test %0d %s: ok", test, test_name(test));
        else
            $display("test %0d %s: %0d errors", test, test_name(test), test_errs[test]);
    endtask

    task automatic check_word(input string name, input word_t exp, input word_t act,
                              input int test);
        checks++;
        if (act !== exp) begin
            $display("mismatch at %0t: %s expected %h, got %h", $time, name, exp, act);
            errors++;
            test_errs[test]++;
        end
    endtask

    task automatic check_addr(input string name, input word_t exp, input word_t act,
                              input int test);
        checks++;
        if (act !== exp) begin
            $display("mismatch at %0t: %s expected 0x%h, got 0x%h", $time, name, exp, act);
            errors++;
            test_errs[test]++;
        end
    endtask

    task automatic check_flag(input string name, input logic exp, input logic act,
                              input int test);
        checks++;
        if (act !== exp) begin
            $display("mismatch at %0t: %s expected %b, got %b", $time, name, exp, act);
            errors++;
            test_errs[test]++;
        end
    endtask

    task automatic load_program();
        int i;
        for (i = 0; i < MEM_WORDS; i++)
            mem[i] = 32'h5a00_0000 ^ 32'(i << 2);
        for (i = 0; i < FILE_WORDS; i++)
            file_buf[i] = 32'hbad0_0000 | 32'(i);
        $readmemh("testbench/program_input.hex", file_buf);
        i = 0;
        while (i < FILE_WORDS && file_buf[i] != MARKER) begin
            mem[PROG_BASE + i] = file_buf[i];
            i++;
        end
        i++;
        while (i + 2 < FILE_WORDS && n_rec < MAX_RECORDS && file_buf[i] != MARKER) begin
            rec_addr[n_rec] = file_buf[i];
            rec_data[n_rec] = file_buf[i + 1];
            rec_test[n_rec] = int'(file_buf[i + 2]);
            n_rec++;
            i += 3;
        end
        if (n_rec == 0) begin
            $display("no expected store records were found in the input file");
            errors++;
        end
    endtask

    // Memory model commits writes and checks them against the records in order
    always @(posedge clk) begin
        if (rst_n && !bus_write)
            check_flag("bus_read_o", 1'b1, bus_read, 5);    // Fetch owns an idle bus
        if (rst_n && bus_write) begin
            mem[bus_address[9:2]] = bus_wrdata;
            if (rec_idx >= n_rec) begin
                $display("unexpected write of %h to %h at %0t after the last expected store",
                         bus_wrdata, bus_address, $time);
                errors++;
                test_errs[5]++;
            end else begin
                check_addr("bus_address_o", rec_addr[rec_idx], bus_address, rec_test[rec_idx]);
                check_word("bus_wrdata_o", rec_data[rec_idx], bus_wrdata, rec_test[rec_idx]);
                rec_idx++;
                if (rec_idx == n_rec || rec_test[rec_idx] != rec_test[rec_idx - 1])
                    report_test(rec_test[rec_idx - 1]);
            end
        end
    end

    initial begin
        int t;
        int cycles;
        int passed;
        clk     = 1'b0;
        rst_n   = 1'b0;
        n_rec   = 0;
        rec_idx = 0;
        checks  = 0;
        errors  = 0;
        passed  = 0;
        for (t = 1; t <= 5; t++) begin
            test_errs[t] = 0;
            test_done[t] = 1'b0;
        end
        load_program();

        repeat (10) begin
            @(negedge clk);
            check_flag("bus_write_o", 1'b0, bus_write, 1);
        end
        @(posedge clk);
        rst_n <= 1'b1;
        @(negedge clk);
        check_flag("bus_write_o", 1'b0, bus_write, 1);   // First cycle out of reset
        report_test(1);

        cycles = 0;
        while (rec_idx < n_rec && cycles < DONE_LIMIT) begin
            @(negedge clk);
            cycles++;
        end
        if (rec_idx < n_rec) begin
            $display("timeout: %0d of %0d expected stores seen within %0d cycles",
                     rec_idx, n_rec, DONE_LIMIT);
            errors++;
            test_errs[5]++;
        end

        // Any write while the program spins in its self loop is extra
        cycles = 0;
        while (cycles < QUIET_CYCLES) begin
            @(negedge clk);
            cycles++;
        end

        for (t = 2; t <= 4; t++) begin
            if (!test_done[t]) begin
                $display("test %0d did not see all of its stores", t);
                errors++;
                test_errs[t]++;
                report_test(t);
            end
        end
        if (dut.u_chk.fail_count != 0) begin
            $display("bus checker reported %0d assertion failures", dut.u_chk.fail_count);
            errors += dut.u_chk.fail_count;
            test_errs[5] += dut.u_chk.fail_count;
        end
        report_test(5);

        for (t = 1; t <= 5; t++) begin
            if (test_errs[t] == 0)
                passed++;
        end
        $display("tests passed: %0d of 5, checks: %0d, errors: %0d", passed, checks, errors);
        if (errors == 0)
            $display("=== PASS ===");
        else
            $display("=== FAIL ===");
        $finish;
    end

endmodule

`default_nettype wire

//--- testbench/program_input.hex
// Program words from address 0, one per line, closed by an ffffffff marker
// Expected stores, one per line: address, data, test number, closed by ffffffff
24140200  // ADDIU r20, r0, 0x200
24010005  // ADDIU r1, r0, 5
2422000e  // ADDIU r2, r1, 14
00221821  // ADDU r3, r1, r2
00612023  // SUBU r4, r3, r1
00832824  // AND r5, r4, r3
00a13025  // OR r6, r5, r1
00244823  // SUBU r9, r1, r4
0126502a  // SLT r10, r9, r6
3c081234  // LUI r8, 0x1234
ae880000  // SW r8, 0(r20)
ae860004  // SW r6, 4(r20)
ae8a0008  // SW r10, 8(r20)
ae89000c  // SW r9, 12(r20)
8c0b0064  // LW r11, 0x64(r0)
01666021  // ADDU r12, r11, r6
ae8c0010  // SW r12, 16(r20)
10820002  // BEQ r4, r2, +2 taken
ae810014  // SW r1, 20(r20) in the delay slot
ae830018  // SW r3, 24(r20) skipped
14210001  // BNE r1, r1, +1 not taken
ae85001c  // SW r5, 28(r20)
ae820020  // SW r2, 32(r20)
1000ffff  // BEQ r0, r0, -1 final self loop
00000000  // NOP
13572468  // Data word read by the LW
ffffffff
00000200 12340000 2
00000204 00000015 2
00000208 00000001 2
0000020c fffffff2 2
00000210 1357247d 3
00000214 00000005 4
0000021c 00000010 4
00000220 00000013 4
ffffffff

//--- all.f
+incdir+common
common/mips_pkg.sv
hw/regfile.sv
hw/bus_arbiter.sv
core/fetch_unit.sv
core/decode_unit.sv
core/exec_unit.sv
core/mem_unit.sv
hw/mips_core_top.sv
testbench/mips_chk.sv
testbench/tb_mips.sv

//--- run.sh
#!/bin/sh
# Builds the MIPS core testbench with Verilator, runs it and checks the log

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f all.f --top-module tb_mips -Mdir obj_dir -o sim
status=$?
if [ "$status" -ne 0 ]; then
    echo "build failed with status $status"
    exit 1
fi

./obj_dir/sim +verilator+error+limit+100 > sim.log 2>&1
status=$?
cat sim.log
if [ "$status" -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "^=== PASS ===$" sim.log; then
    echo "result: pass"
    exit 0
else
    echo "result: fail"
    exit 1
fi
